// File: mini_mcu.f
design/mini_mcu_pkg.sv
design/system_bus.sv
design/memory_subsystem.sv
design/dma_engine.sv
design/ao_peripheral_subsystem.sv
design/peripheral_subsystem.sv
design/mini_mcu.sv
testbench/tb_mini_mcu.sv

// File: Makefile
TOP = tb_mini_mcu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f mini_mcu.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f mini_mcu.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: testbench/tb_mini_mcu_patterns.txt
# test op addr be data err, all but test and err in hex
# W write, R read, P poll read, X xorshift fill, C copy check, S pin check
# X and C: be column is a word count, C: data column is the source address
# S: addr 0 gpio_o, 1 gpio_en_o, 2 irq_o, 3 exit_valid_o, 4 exit_value_o
1 X 00000000 10 00000000 0
1 W 00000040 f 11223344 0
1 W 00000040 3 aabbccdd 0
1 R 00000040 f 1122ccdd 0
2 R 10000000 f badcab1e 1
2 W 10000000 f 12345678 1
2 W 00001000 f 87654321 1
2 R 00001000 f badcab1e 1
2 C 00000000 1 00000000 0
2 R 00000040 f 1122ccdd 0
3 W 30000000 f a5a50f0f 0
3 W 30000004 f 0000ffff 0
3 S 00000000 0 a5a50f0f 0
3 S 00000001 0 0000ffff 0
3 R 30000000 f a5a50f0f 0
3 R 30000008 f 3c3c0f0f 0
4 W 20000010 f 00000000 0
4 W 20000014 f 00000400 0
4 W 20000018 f 00000008 0
4 P 3000000c f 00000001 0
4 S 00000002 0 00000001 0
4 C 00000400 8 00000000 0
4 W 3000000c f 00000001 0
4 S 00000002 0 00000000 0
5 W 20000014 f 00000800 0
5 W 20000018 f 00000010 0
5 W 00000c00 f 0badf00d 0
5 W 00000c04 f 5ee5a11e 0
5 R 00000c00 f 0badf00d 0
5 R 00000c04 f 5ee5a11e 0
5 P 3000000c f 00000001 0
5 C 00000800 10 00000000 0
6 S 00000003 0 00000000 0
6 R 20000004 f 00000001 0
6 W 20000000 f 0000002a 0
6 S 00000003 0 00000001 0
6 S 00000004 0 0000002a 0

// File: testbench/tb_mini_mcu.sv
// testbench for the mini MCU
// drives the external bus port from a pattern file, with GPIO loopback
`timescale 1ns/1ps

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam int          CLK_PERIOD = 20;
  localparam int          MAX_OPS    = 128;
  localparam int          POLL_LIMIT = 500;
  localparam logic [31:0] LOOP_FILL  = 32'h3C3C_5A5A;

  logic        clk;
  logic        reset;
  logic        boot_select;
  obi_req_t    ext_req;
  obi_resp_t   ext_resp;
  logic [31:0] exit_value;
  logic        exit_valid;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_en;
  logic        irq;

  int          n_ops;
  int          pat_test [MAX_OPS];
  logic [7:0]  pat_op   [MAX_OPS];
  logic [31:0] pat_addr [MAX_OPS];
  logic [31:0] pat_be   [MAX_OPS];
  logic [31:0] pat_data [MAX_OPS];
  logic        pat_err  [MAX_OPS];
  // expected RAM contents as written from the external port
  logic [31:0] shadow   [RAM_WORDS];
  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          test_errors;
  bit          loaded = 1'b0;

  mini_mcu UUT (
    .clk_i            (clk),
    .reset_i          (reset),
    .boot_select_i    (boot_select),
    .ext_master_req_i (ext_req),
    .ext_master_resp_o(ext_resp),
    .exit_value_o     (exit_value),
    .exit_valid_o     (exit_valid),
    .gpio_i           (gpio_in),
    .gpio_o           (gpio_out),
    .gpio_en_o        (gpio_en),
    .irq_o            (irq)
  );

  initial begin
    clk = 1'b0;
    gpio_in = LOOP_FILL;
    forever begin
      #(CLK_PERIOD / 2) clk = 1'b1;
      #(CLK_PERIOD / 2) clk = 1'b0;
      // enabled pins loop back and the rest sit at a fixed level
      gpio_in = (gpio_out & gpio_en) | (LOOP_FILL & ~gpio_en);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    test_errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic shadow_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        shadow[addr[11:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // one transfer on the external port with the response one cycle after the grant
  task automatic bus_op(input logic we, input logic [3:0] be, input logic [31:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output logic err);
    int waited;
    waited = 0;
    rdata = 32'h0;
    err = 1'b0;
    @(negedge clk);
    ext_req.req   = 1'b1;
    ext_req.we    = we;
    ext_req.be    = be;
    ext_req.addr  = addr;
    ext_req.wdata = wdata;
    #1;
    while (!ext_resp.gnt && waited < POLL_LIMIT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    @(negedge clk);
    if (waited >= POLL_LIMIT) begin
      report_error("external request was never granted");
    end else begin
      if (!ext_resp.rvalid) begin
        report_error("no rvalid in the cycle after the grant");
      end
      rdata = ext_resp.rdata;
      err   = ext_resp.err;
    end
    ext_req.req = 1'b0;
  endtask

  task automatic load_patterns();
    int          fd;
    int          t;
    int          e;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] be;
    logic [31:0] d;
    n_ops = 0;
    fd = $fopen("testbench/tb_mini_mcu_patterns.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the pattern file");
      return;
    end
    while (!$feof(fd) && n_ops < MAX_OPS) begin
      line = "";
      n = $fgets(line, fd);
      // comment and empty lines do not match the six fields
      if (n > 0 && $sscanf(line, "%d %c %h %h %h %d", t, op, a, be, d, e) == 6) begin
        pat_test[n_ops] = t;
        pat_op[n_ops]   = op;
        pat_addr[n_ops] = a;
        pat_be[n_ops]   = be;
        pat_data[n_ops] = d;
        pat_err[n_ops]  = (e != 0);
        n_ops++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(input int i);
    logic [31:0] rdata;
    logic        err;
    logic [31:0] a;
    logic [31:0] src;
    int          count;
    int          polls;
    count = int'(pat_be[i]);
    case (pat_op[i])
      "W": begin
        bus_op(1'b1, pat_be[i][3:0], pat_addr[i], pat_data[i], rdata, err);
        check_value("ext_master_resp_o.err", {31'h0, pat_err[i]}, {31'h0, err});
        if (!pat_err[i] && pat_addr[i] < RAM_WORDS * 4) begin
          shadow_write(pat_addr[i], pat_be[i][3:0], pat_data[i]);
        end
      end
      "R": begin
        bus_op(1'b0, 4'hF, pat_addr[i], 32'h0, rdata, err);
        check_value("ext_master_resp_o.rdata", pat_data[i], rdata);
        check_value("ext_master_resp_o.err", {31'h0, pat_err[i]}, {31'h0, err});
      end
      "P": begin
        polls = 0;
        do begin
          bus_op(1'b0, 4'hF, pat_addr[i], 32'h0, rdata, err);
          polls++;
        end while (rdata !== pat_data[i] && polls < POLL_LIMIT);
        if (rdata !== pat_data[i]) begin
          report_error("polled register never reached the expected value");
        end
        check_value("ext_master_resp_o.err", {31'h0, pat_err[i]}, {31'h0, err});
      end
      "X": begin
        for (int k = 0; k < count; k++) begin
          a = pat_addr[i] + 4 * k;
          rng_state = xorshift32(rng_state);
          bus_op(1'b1, 4'hF, a, rng_state, rdata, err);
          check_value("ext_master_resp_o.err", 32'h0, {31'h0, err});
          shadow_write(a, 4'hF, rng_state);
        end
        for (int k = 0; k < count; k++) begin
          a = pat_addr[i] + 4 * k;
          bus_op(1'b0, 4'hF, a, 32'h0, rdata, err);
          check_value("ext_master_resp_o.rdata", shadow[a[11:2]], rdata);
        end
      end
      "C": begin
        // destination words must match what was written at the source
        for (int k = 0; k < count; k++) begin
          a = pat_addr[i] + 4 * k;
          src = pat_data[i] + 4 * k;
          bus_op(1'b0, 4'hF, a, 32'h0, rdata, err);
          check_value("ext_master_resp_o.rdata", shadow[src[11:2]], rdata);
          check_value("ext_master_resp_o.err", 32'h0, {31'h0, err});
        end
      end
      "S": begin
        @(negedge clk);
        case (pat_addr[i])
          32'd0:   check_value("gpio_o", pat_data[i], gpio_out);
          32'd1:   check_value("gpio_en_o", pat_data[i], gpio_en);
          32'd2:   check_value("irq_o", pat_data[i], {31'h0, irq});
          32'd3:   check_value("exit_valid_o", pat_data[i], {31'h0, exit_valid});
          default: check_value("exit_value_o", pat_data[i], exit_value);
        endcase
      end
      default: report_error("unknown operation in the pattern file");
    endcase
  endtask

  task automatic print_test_result(input int t);
    $display("test %0d %s (%0d errors)", t, (test_errors == 0) ? "ok" : "bad", test_errors);
    test_errors = 0;
  endtask

  initial begin
    int prev_test;
    int tests;
    reset = 1'b1;
    boot_select = 1'b1;
    ext_req = '0;
    rng_state = 32'h5aa0;
    checks = 0;
    errors = 0;
    test_errors = 0;
    tests = 0;
    load_patterns();
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    prev_test = (n_ops > 0) ? pat_test[0] : 0;
    for (int i = 0; i < n_ops; i++) begin
      if (pat_test[i] != prev_test) begin
        print_test_result(prev_test);
        tests++;
        prev_test = pat_test[i];
      end
      run_op(i);
    end
    if (n_ops > 0) begin
      print_test_result(prev_test);
      tests++;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && n_ops > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog scaled by the number of pattern lines
  initial begin
    wait (loaded);
    #(CLK_PERIOD * (n_ops * 200 + 20));
    $display("ERROR watchdog expired before the pattern run finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: design/mini_mcu.sv
// mini MCU top level
// system bus with external master port, RAM, always-on and GPIO blocks
`timescale 1ns/1ps

module mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        boot_select_i,
  input  obi_req_t    ext_master_req_i,
  output obi_resp_t   ext_master_resp_o,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o,
  input  logic [31:0] gpio_i,
  output logic [31:0] gpio_o,
  output logic [31:0] gpio_en_o,
  output logic        irq_o
);

  // DMA master
  obi_req_t  dma_master_req;
  obi_resp_t dma_master_resp;

  // targets
  obi_req_t  ram_req;
  obi_resp_t ram_resp;
  obi_req_t  ao_req;
  obi_resp_t ao_resp;
  obi_req_t  periph_req;
  obi_resp_t periph_resp;

  logic dma_done;

  system_bus system_bus_i (
    .clk_i,
    .reset_i,
    .ext_master_req_i,
    .ext_master_resp_o,
    .dma_master_req_i (dma_master_req),
    .dma_master_resp_o(dma_master_resp),
    .ram_req_o        (ram_req),
    .ram_resp_i       (ram_resp),
    .ao_req_o         (ao_req),
    .ao_resp_i        (ao_resp),
    .periph_req_o     (periph_req),
    .periph_resp_i    (periph_resp)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .reset_i,
    .req_i (ram_req),
    .resp_o(ram_resp)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .reset_i,
    .req_i            (ao_req),
    .resp_o           (ao_resp),
    .boot_select_i,
    .exit_value_o,
    .exit_valid_o,
    .dma_master_req_o (dma_master_req),
    .dma_master_resp_i(dma_master_resp),
    .dma_done_o       (dma_done)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i,
    .reset_i,
    .req_i     (periph_req),
    .resp_o    (periph_resp),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .dma_done_i(dma_done),
    .irq_o
  );

endmodule

// File: design/peripheral_subsystem.sv
// GPIO registers with input synchronizer, DMA done interrupt status
`timescale 1ns/1ps

module peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  obi_req_t    req_i,
  output obi_resp_t   resp_o,
  input  logic [31:0] gpio_i,
  output logic [31:0] gpio_o,
  output logic [31:0] gpio_en_o,
  input  logic        dma_done_i,
  output logic        irq_o
);

  logic [7:0]  off;
  logic        wr_en;
  logic [31:0] gpio_out_q;
  logic [31:0] gpio_en_q;
  logic [31:0] gpio_meta_q;
  logic [31:0] gpio_sync_q;
  logic        intr_q;
  logic        intr_clr;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        rvalid_q;

  assign off      = req_i.addr[7:0];
  assign wr_en    = req_i.req && req_i.we;
  assign intr_clr = wr_en && (off == INTR_STATUS) && req_i.wdata[0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q  <= 32'h0;
      gpio_en_q   <= 32'h0;
      gpio_meta_q <= 32'h0;
      gpio_sync_q <= 32'h0;
      intr_q      <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      rvalid_q    <= req_i.req;
      if (wr_en && (off == GPIO_OUT)) gpio_out_q <= req_i.wdata;
      if (wr_en && (off == GPIO_EN)) gpio_en_q <= req_i.wdata;
      // a new done wins over a clear in the same cycle
      intr_q <= dma_done_i || (intr_q && !intr_clr);
    end
  end

  always_comb begin
    case (off)
      GPIO_OUT:    rdata_d = gpio_out_q;
      GPIO_EN:     rdata_d = gpio_en_q;
      GPIO_IN:     rdata_d = gpio_sync_q;
      INTR_STATUS: rdata_d = {31'h0, intr_q};
      default:     rdata_d = 32'h0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= req_i.we ? 32'h0 : rdata_d;
  end

  assign resp_o    = '{gnt: req_i.req, rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign gpio_o    = gpio_out_q;
  assign gpio_en_o = gpio_en_q;
  assign irq_o     = intr_q;

endmodule

// File: design/ao_peripheral_subsystem.sv
// always-on peripherals: exit register, boot select, DMA control
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  obi_req_t    req_i,
  output obi_resp_t   resp_o,
  input  logic        boot_select_i,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o,
  output obi_req_t    dma_master_req_o,
  input  obi_resp_t   dma_master_resp_i,
  output logic        dma_done_o
);

  logic [7:0]  off;
  logic        wr_en;
  logic        dma_start;
  logic        dma_busy;
  logic [31:0] dma_src_q;
  logic [31:0] dma_dst_q;
  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        rvalid_q;

  assign off   = req_i.addr[7:0];
  assign wr_en = req_i.req && req_i.we;
  // length goes straight to the engine with the start pulse
  assign dma_start = wr_en && (off == AO_DMA_LEN);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_value_q <= 32'h0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && (off == AO_EXIT_VALUE)) begin
        exit_value_q <= req_i.wdata;
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && (off == AO_DMA_SRC)) begin
      dma_src_q <= req_i.wdata;
    end
    if (wr_en && (off == AO_DMA_DST)) begin
      dma_dst_q <= req_i.wdata;
    end
    if (req_i.req) begin
      rdata_q <= req_i.we ? 32'h0 : rdata_d;
    end
  end

  always_comb begin
    case (off)
      AO_EXIT_VALUE:  rdata_d = exit_value_q;
      AO_BOOT_SELECT: rdata_d = {31'h0, boot_select_i};
      AO_DMA_SRC:     rdata_d = dma_src_q;
      AO_DMA_DST:     rdata_d = dma_dst_q;
      AO_DMA_STATUS:  rdata_d = {31'h0, dma_busy};
      default:        rdata_d = 32'h0;
    endcase
  end

  assign resp_o       = '{gnt: req_i.req, rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  dma_engine dma_engine_i (
    .clk_i,
    .reset_i,
    .start_i      (dma_start),
    .src_i        (dma_src_q),
    .dst_i        (dma_dst_q),
    .len_i        (req_i.wdata[15:0]),
    .busy_o       (dma_busy),
    .done_o       (dma_done_o),
    .master_req_o (dma_master_req_o),
    .master_resp_i(dma_master_resp_i)
  );

endmodule

// File: design/dma_engine.sv
// word copy DMA, one read then one write per word on its own bus port
`timescale 1ns/1ps

module dma_engine
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        start_i,
  input  logic [31:0] src_i,
  input  logic [31:0] dst_i,
  input  logic [15:0] len_i,
  output logic        busy_o,
  output logic        done_o,
  output obi_req_t    master_req_o,
  input  obi_resp_t   master_resp_i
);

  dma_state_e  state_q;
  logic        done_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [15:0] count_q;
  logic [31:0] data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          // zero length finishes without touching the bus
          if (start_i) begin
            if (len_i == 16'd0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= READ;
            end
          end
        end
        READ:      if (master_resp_i.gnt) state_q <= READ_WAIT;
        READ_WAIT: if (master_resp_i.rvalid) state_q <= WRITE;
        WRITE:     if (master_resp_i.gnt) state_q <= WRITE_WAIT;
        WRITE_WAIT: begin
          if (master_resp_i.rvalid) begin
            if (count_q == 16'd0) begin
              state_q <= IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= READ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      src_q   <= src_i;
      dst_q   <= dst_i;
      count_q <= len_i;
    end
    if (state_q == READ && master_resp_i.gnt) begin
      src_q <= src_q + 32'd4;
    end
    if (state_q == READ_WAIT && master_resp_i.rvalid) begin
      data_q <= master_resp_i.rdata;
    end
    if (state_q == WRITE && master_resp_i.gnt) begin
      dst_q   <= dst_q + 32'd4;
      count_q <= count_q - 16'd1;
    end
  end

  always_comb begin
    master_req_o.req   = (state_q == READ) || (state_q == WRITE);
    master_req_o.we    = (state_q == WRITE);
    master_req_o.be    = 4'hF;
    master_req_o.addr  = (state_q == WRITE) ? dst_q : src_q;
    master_req_o.wdata = data_q;
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = done_q;

endmodule

// File: design/memory_subsystem.sv
// word RAM with byte enables, one-cycle read response
`timescale 1ns/1ps

module memory_subsystem
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [31:0]           mem [RAM_WORDS];
  logic [RAM_ADDR_W-1:0] idx;
  logic [31:0]           rdata_q;
  logic                  rvalid_q;

  assign idx = req_i.addr[RAM_ADDR_W+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
    // writes answer with zero data
    if (req_i.req) begin
      rdata_q <= req_i.we ? 32'h0 : mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o = '{gnt: req_i.req, rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

// File: design/system_bus.sv
// system bus with two masters and three targets
// fixed priority for the external port, address decode, response routing
`timescale 1ns/1ps

module system_bus
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  obi_req_t  ext_master_req_i,
  output obi_resp_t ext_master_resp_o,
  input  obi_req_t  dma_master_req_i,
  output obi_resp_t dma_master_resp_o,
  output obi_req_t  ram_req_o,
  input  obi_resp_t ram_resp_i,
  output obi_req_t  ao_req_o,
  input  obi_resp_t ao_resp_i,
  output obi_req_t  periph_req_o,
  input  obi_resp_t periph_resp_i
);

  obi_req_t    sel_req;
  bus_target_e sel_target;
  logic        sel_dma;
  logic        sel_gnt;
  logic        accept;
  bus_target_e rsp_target_q;
  logic        rsp_dma_q;
  logic        err_pending_q;
  obi_resp_t   rsp;

  // external port wins whenever it requests
  assign sel_dma = ~ext_master_req_i.req;
  assign sel_req = sel_dma ? dma_master_req_i : ext_master_req_i;

  always_comb begin
    if ((sel_req.addr - RAM_BASE) < RAM_SIZE) begin
      sel_target = RAM;
    end else if ((sel_req.addr - AO_BASE) < PERIPH_SPAN) begin
      sel_target = AO;
    end else if ((sel_req.addr - PERIPH_BASE) < PERIPH_SPAN) begin
      sel_target = PERIPH;
    end else begin
      sel_target = NONE;
    end
  end

  // targets see addresses relative to their base
  always_comb begin
    ram_req_o         = sel_req;
    ram_req_o.req     = sel_req.req && (sel_target == RAM);
    ram_req_o.addr    = sel_req.addr - RAM_BASE;
    ao_req_o          = sel_req;
    ao_req_o.req      = sel_req.req && (sel_target == AO);
    ao_req_o.addr     = sel_req.addr - AO_BASE;
    periph_req_o      = sel_req;
    periph_req_o.req  = sel_req.req && (sel_target == PERIPH);
    periph_req_o.addr = sel_req.addr - PERIPH_BASE;
  end

  always_comb begin
    case (sel_target)
      RAM:     sel_gnt = ram_resp_i.gnt;
      AO:      sel_gnt = ao_resp_i.gnt;
      PERIPH:  sel_gnt = periph_resp_i.gnt;
      default: sel_gnt = sel_req.req;
    endcase
  end

  assign accept = sel_req.req && sel_gnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_target_q  <= NONE;
      rsp_dma_q     <= 1'b0;
      err_pending_q <= 1'b0;
    end else begin
      err_pending_q <= accept && (sel_target == NONE);
      if (accept) begin
        rsp_target_q <= sel_target;
        rsp_dma_q    <= sel_dma;
      end
    end
  end

  // response of the transfer accepted in the previous cycle
  always_comb begin
    case (rsp_target_q)
      RAM:     rsp = ram_resp_i;
      AO:      rsp = ao_resp_i;
      PERIPH:  rsp = periph_resp_i;
      default: rsp = '{gnt: 1'b0, rvalid: err_pending_q, err: 1'b1, rdata: ERR_RDATA};
    endcase
    ext_master_resp_o        = rsp;
    ext_master_resp_o.gnt    = accept && !sel_dma;
    ext_master_resp_o.rvalid = rsp.rvalid && !rsp_dma_q;
    dma_master_resp_o        = rsp;
    dma_master_resp_o.gnt    = accept && sel_dma;
    dma_master_resp_o.rvalid = rsp.rvalid && rsp_dma_q;
  end

endmodule

// File: design/mini_mcu_pkg.sv
// mini MCU shared definitions
// bus structs, address map, register offsets and FSM encodings
package mini_mcu_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // address map
  localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
  localparam int unsigned RAM_WORDS   = 1024;
  localparam int unsigned RAM_ADDR_W  = $clog2(RAM_WORDS);
  localparam logic [31:0] RAM_SIZE    = RAM_WORDS * 4;
  localparam logic [31:0] AO_BASE     = 32'h2000_0000;
  localparam logic [31:0] PERIPH_BASE = 32'h3000_0000;
  localparam logic [31:0] PERIPH_SPAN = 32'h0000_0100;

  // always-on block registers
  localparam logic [7:0] AO_EXIT_VALUE  = 8'h00;
  localparam logic [7:0] AO_BOOT_SELECT = 8'h04;
  localparam logic [7:0] AO_DMA_SRC     = 8'h10;
  localparam logic [7:0] AO_DMA_DST     = 8'h14;
  localparam logic [7:0] AO_DMA_LEN     = 8'h18;
  localparam logic [7:0] AO_DMA_STATUS  = 8'h1C;

  // peripheral block registers
  localparam logic [7:0] GPIO_OUT    = 8'h00;
  localparam logic [7:0] GPIO_EN     = 8'h04;
  localparam logic [7:0] GPIO_IN     = 8'h08;
  localparam logic [7:0] INTR_STATUS = 8'h0C;

  localparam logic [31:0] ERR_RDATA = 32'hBADC_AB1E;

  typedef enum logic [1:0] {RAM, AO, PERIPH, NONE} bus_target_e;

  typedef enum logic [2:0] {IDLE, READ, READ_WAIT, WRITE, WRITE_WAIT} dma_state_e;

endpackage
